//--- include/tile_gfx_consts.svh
`ifndef TILE_GFX_CONSTS_SVH
`define TILE_GFX_CONSTS_SVH

// Visible pixels per display line
`define TG_LINE_WIDTH 320

// Tile columns fetched per line, one extra for fine scroll
`define TG_NUM_COLS 41

// First bitmap line relative to vline
`define TG_LINE_OFFSET 15

// Entries in each line buffer bank
`define TG_BUF_DEPTH 512

// VRAM word address width
`define TG_VADDR_W 13

`endif

//--- rtl/line_buffer.sv
`timescale 1ns/1ns

`include "tile_gfx_consts.svh"

module line_buffer (
    input  logic       clk,

    // Selects the bank being written
    input  logic       bank_sel,

    input  logic [8:0] wr_idx,
    input  logic [5:0] wr_data,
    input  logic       wr_en,

    input  logic [8:0] rd_idx,
    output logic [5:0] rd_data
);

    logic [5:0] bank0 [0:`TG_BUF_DEPTH-1];
    logic [5:0] bank1 [0:`TG_BUF_DEPTH-1];

    //////////////////////////////
    // Write side
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en && !bank_sel) begin
            bank0[wr_idx] <= wr_data;
        end
        if (wr_en && bank_sel) begin
            bank1[wr_idx] <= wr_data;
        end
    end

    //////////////////////////////
    // Read side
    //////////////////////////////

    // Display reads the bank that is not being filled
    always_ff @(posedge clk) begin
        if (bank_sel) begin
            rd_data <= bank0[rd_idx];
        end else begin
            rd_data <= bank1[rd_idx];
        end
    end

endmodule

//--- rtl/tile_fetcher.sv
`timescale 1ns/1ns

`include "tile_gfx_consts.svh"

module tile_fetcher (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   start,
    input  logic [8:0]             scrx,
    input  logic [7:0]             scry,
    input  logic [7:0]             vline,

    // Synchronous VRAM, vaddr is the address for the next cycle
    output logic [`TG_VADDR_W-1:0] vaddr,
    input  logic [15:0]            vdata,

    output logic                   line_busy,

    tile_render_if.fetch           rif
);

    tile_gfx_pkg::fetch_state_t state_r, state_next;
    tile_gfx_pkg::map_entry_t   map_r, map_next;
    tile_gfx_pkg::map_entry_t   entry;

    logic [`TG_VADDR_W-1:0] vaddr_r, vaddr_next;
    logic [5:0]             col_r, col_next;
    logic [5:0]             col_cnt_r, col_cnt_next;
    logic [8:0]             idx_r, idx_next;
    logic                   busy_r, busy_next;
    logic                   render_go;
    logic                   can_start;

    logic [7:0]             bm_line;
    logic [7:0]             t_line;
    logic [2:0]             tile_row;
    logic [`TG_VADDR_W-1:0] pat_first;
    logic [`TG_VADDR_W-1:0] pat_second;

    //////////////////////////////
    // Address arithmetic
    //////////////////////////////

    assign bm_line = vline - 8'(`TG_LINE_OFFSET);
    assign t_line  = bm_line + scry;

    // Map word arrives on vdata while in FETCH_MAP
    assign entry = (state_r == tile_gfx_pkg::FETCH_MAP) ?
                   tile_gfx_pkg::map_entry_t'(vdata) : map_r;

    assign tile_row   = entry.vflip ? ~t_line[2:0] : t_line[2:0];
    assign pat_first  = {entry.tile_idx, tile_row, entry.hflip};
    assign pat_second = {entry.tile_idx, tile_row, ~entry.hflip};

    function automatic logic [`TG_VADDR_W-1:0] map_addr(input logic [4:0] row,
                                                          input logic [5:0] col);
        return {2'b00, row, col};
    endfunction

    assign can_start = !rif.busy || rif.last_pixel;

    //////////////////////////////
    // Fetch FSM
    //////////////////////////////

    always_comb begin
        state_next   = state_r;
        map_next     = map_r;
        vaddr_next   = vaddr_r;
        col_next     = col_r;
        col_cnt_next = col_cnt_r;
        idx_next     = idx_r;
        busy_next    = busy_r;
        render_go    = 1'b0;

        if (start) begin
            // Restart the line at the coarse scroll column
            state_next   = tile_gfx_pkg::FETCH_MAP;
            vaddr_next   = map_addr(t_line[7:3], scrx[8:3]);
            col_next     = scrx[8:3];
            col_cnt_next = 6'd0;
            idx_next     = 9'd0 - {6'd0, scrx[2:0]};
            busy_next    = 1'b1;
        end else if (busy_r) begin
            case (state_r)
                tile_gfx_pkg::FETCH_MAP: begin
                    map_next     = entry;
                    vaddr_next   = pat_first;
                    col_next     = col_r + 6'd1;
                    col_cnt_next = col_cnt_r + 6'd1;
                    state_next   = tile_gfx_pkg::FETCH_PAT_A;
                end

                // Address is held while stalled, so vdata stays valid
                tile_gfx_pkg::FETCH_PAT_A: begin
                    if (can_start) begin
                        render_go  = 1'b1;
                        vaddr_next = pat_second;
                        state_next = tile_gfx_pkg::FETCH_PAT_B;
                    end
                end

                tile_gfx_pkg::FETCH_PAT_B: begin
                    if (can_start) begin
                        render_go  = 1'b1;
                        vaddr_next = map_addr(t_line[7:3], col_r);
                        if (col_cnt_r == 6'(`TG_NUM_COLS)) begin
                            state_next = tile_gfx_pkg::FETCH_DONE;
                        end else begin
                            state_next = tile_gfx_pkg::FETCH_MAP;
                        end
                    end
                end

                tile_gfx_pkg::FETCH_DONE: begin
                    // Line ends with the final pixel written
                    if (rif.last_pixel) begin
                        busy_next = 1'b0;
                    end
                end

                default: begin
                    state_next = tile_gfx_pkg::FETCH_DONE;
                end
            endcase

            if (render_go) begin
                idx_next = idx_r + 9'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_r   <= tile_gfx_pkg::FETCH_DONE;
            vaddr_r   <= '0;
            col_r     <= 6'd0;
            col_cnt_r <= 6'd0;
            idx_r     <= 9'd0;
            busy_r    <= 1'b0;
        end else begin
            state_r   <= state_next;
            vaddr_r   <= vaddr_next;
            col_r     <= col_next;
            col_cnt_r <= col_cnt_next;
            idx_r     <= idx_next;
            busy_r    <= busy_next;
        end
    end

    always_ff @(posedge clk) begin
        map_r <= map_next;
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign vaddr     = vaddr_next;
    assign line_busy = busy_r;

    assign rif.render_start = render_go;
    assign rif.render_idx   = idx_r;
    assign rif.render_data  = vdata;
    assign rif.palette      = map_r.palette;
    assign rif.hflip        = map_r.hflip;

endmodule

//--- rtl/tile_gfx.sv
`timescale 1ns/1ns

`include "tile_gfx_consts.svh"

module tile_gfx (
    input  logic                   clk,
    input  logic                   reset,

    // Scroll and line select
    input  logic [8:0]             scrx,
    input  logic [7:0]             scry,
    input  logic [7:0]             vline,
    input  logic                   start,

    // VRAM
    output logic [`TG_VADDR_W-1:0] vaddr,
    input  logic [15:0]            vdata,

    // Display readout
    input  logic [8:0]             rd_idx,
    output logic [5:0]             rd_data,

    output logic                   line_busy
);

    logic       bank_sel;
    logic [8:0] wr_idx;
    logic [5:0] wr_data;
    logic       wr_en;

    tile_render_if rif ();

    //////////////////////////////
    // Bank select
    //////////////////////////////

    // Each new line swaps the write and read banks
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_sel <= 1'b0;
        end else if (start) begin
            bank_sel <= ~bank_sel;
        end
    end

    //////////////////////////////
    // Blocks
    //////////////////////////////

    tile_fetcher u_fetcher (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .scrx      (scrx),
        .scry      (scry),
        .vline     (vline),
        .vaddr     (vaddr),
        .vdata     (vdata),
        .line_busy (line_busy),
        .rif       (rif)
    );

    tile_renderer u_renderer (
        .clk     (clk),
        .reset   (reset),
        .rif     (rif),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .wr_en   (wr_en)
    );

    line_buffer u_line_buffer (
        .clk      (clk),
        .bank_sel (bank_sel),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .wr_en    (wr_en),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

endmodule

//--- rtl/tile_gfx_pkg.sv
package tile_gfx_pkg;

    // Per-column fetch sequence
    typedef enum logic [1:0] {
        FETCH_MAP   = 2'd0,
        FETCH_PAT_A = 2'd1,
        FETCH_PAT_B = 2'd2,
        FETCH_DONE  = 2'd3
    } fetch_state_t;

    // One word of the tile map, MSB first
    typedef struct packed {
        logic       unused_hi;
        // Priority bit, no sprites here so it has no effect
        logic       prio;
        logic [1:0] palette;
        logic       unused_lo;
        logic       vflip;
        logic       hflip;
        logic [8:0] tile_idx;
    } map_entry_t;

endpackage

//--- rtl/tile_render_if.sv
`timescale 1ns/1ns

interface tile_render_if;

    // Driven by the fetcher
    logic [8:0]  render_idx;
    logic [15:0] render_data;
    logic        render_start;
    logic [1:0]  palette;
    logic        hflip;

    // Driven by the renderer
    logic        busy;
    logic        last_pixel;

    modport fetch (
        output render_idx, render_data, render_start, palette, hflip,
        input  busy, last_pixel
    );

    modport render (
        input  render_idx, render_data, render_start, palette, hflip,
        output busy, last_pixel
    );

endinterface

//--- rtl/tile_renderer.sv
`timescale 1ns/1ns

`include "tile_gfx_consts.svh"

module tile_renderer (
    input  logic                 clk,
    input  logic                 reset,

    tile_render_if.render        rif,

    // Line buffer write port
    output logic [8:0]           wr_idx,
    output logic [5:0]           wr_data,
    output logic                 wr_en
);

    logic [15:0] shift_r;
    logic [8:0]  idx_r;
    logic [1:0]  pal_r;
    logic [1:0]  cnt_r;
    logic        busy_r;

    logic [15:0] word_ordered;

    //////////////////////////////
    // Pixel order
    //////////////////////////////

    // Mirrored words have their nibbles swapped end for end,
    // so the shifter always takes the top nibble first
    always_comb begin
        if (rif.hflip) begin
            word_ordered = {rif.render_data[3:0], rif.render_data[7:4],
                            rif.render_data[11:8], rif.render_data[15:12]};
        end else begin
            word_ordered = rif.render_data;
        end
    end

    //////////////////////////////
    // Control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_r <= 1'b0;
            cnt_r  <= 2'd0;
        end else if (rif.render_start) begin
            busy_r <= 1'b1;
            cnt_r  <= 2'd0;
        end else if (busy_r) begin
            cnt_r <= cnt_r + 2'd1;
            if (cnt_r == 2'd3) begin
                busy_r <= 1'b0;
            end
        end
    end

    // Word, index and palette of the current render
    always_ff @(posedge clk) begin
        if (rif.render_start) begin
            shift_r <= word_ordered;
            idx_r   <= rif.render_idx;
            pal_r   <= rif.palette;
        end else if (busy_r) begin
            shift_r <= {shift_r[11:0], 4'h0};
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign rif.busy       = busy_r;
    assign rif.last_pixel = busy_r && (cnt_r == 2'd3);

    assign wr_idx  = idx_r + {7'd0, cnt_r};
    assign wr_data = {pal_r, shift_r[15:12]};

    // Scroll tile pixels wrap past the line end and are dropped
    assign wr_en = busy_r && (wr_idx < 9'(`TG_LINE_WIDTH));

endmodule

//--- tb/tile_gfx_checker.sv
`timescale 1ns/1ns

`include "tile_gfx_consts.svh"

module tile_gfx_checker (
    input logic       clk,
    input logic       reset,
    input logic       wr_en,
    input logic [8:0] wr_idx,
    input logic       line_busy,
    input logic       render_start,
    input logic       busy,
    input logic       last_pixel
);

    //////////////////////////////
    // Write port
    //////////////////////////////

    a_wr_in_line: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (wr_idx < 9'(`TG_LINE_WIDTH)))
        else $error("Line buffer write beyond the visible line");

    // Writes belong to a line in progress
    a_wr_while_busy: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> line_busy)
        else $error("Line buffer write while no line is busy");

    //////////////////////////////
    // Renderer handshake
    //////////////////////////////

    a_start_allowed: assert property (@(posedge clk) disable iff (reset)
        render_start |-> (!busy || last_pixel))
        else $error("Render started while the renderer was busy");

    // Idle state after reset
    a_reset_idle: assert property (@(posedge clk)
        reset |=> (!line_busy && !wr_en))
        else $error("Line busy or write active after reset");

endmodule

//--- tb/tile_gfx_tb.sv
`timescale 1ns/1ns

`include "tile_gfx_consts.svh"

module tile_gfx_tb;

    localparam int num_lines = 40;
    // 40 lines of about 400 + 330 + 20 cycles, rounded up
    localparam int timeout_cycles = 32000;

    logic        clk;
    logic        reset;
    logic [8:0]  scrx;
    logic [7:0]  scry;
    logic [7:0]  vline;
    logic        start;
    logic [15:0] vdata;
    logic [8:0]  rd_idx;
    logic [12:0] vaddr;
    logic [5:0]  rd_data;
    logic        line_busy;

    logic [15:0] vram [0:8191];
    integer      seed;
    int          cycle_count;

    // Line whose pixels sit in the read bank
    logic [8:0]  prev_scrx;
    logic [7:0]  prev_scry;
    logic [7:0]  prev_vline;
    string       prev_name;
    string       cur_name;

    tile_gfx i_dut (
        .clk       (clk),
        .reset     (reset),
        .scrx      (scrx),
        .scry      (scry),
        .vline     (vline),
        .start     (start),
        .vaddr     (vaddr),
        .vdata     (vdata),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data),
        .line_busy (line_busy)
    );

    bind tile_gfx tile_gfx_checker i_checker (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .line_busy    (line_busy),
        .render_start (rif.render_start),
        .busy         (rif.busy),
        .last_pixel   (rif.last_pixel)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Synchronous VRAM
    always @(posedge clk) begin
        vdata <= vram[vaddr];
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [5:0] model_pixel(input logic [8:0] sx, input logic [7:0] sy,
                                               input logic [7:0] vl, input int i);
        logic [7:0]  t;
        logic [8:0]  p;
        logic [15:0] ent;
        logic [2:0]  row_in_tile;
        logic [2:0]  tile_px;
        logic [15:0] word;
        int          k;
        t = vl - 8'(`TG_LINE_OFFSET) + sy;
        p = 9'(i) + sx;
        ent = vram[{2'b00, t[7:3], p[8:3]}];
        // vflip in bit 10, hflip in bit 9
        row_in_tile = ent[10] ? ~t[2:0] : t[2:0];
        tile_px = ent[9] ? 3'd7 - p[2:0] : p[2:0];
        word = vram[{ent[8:0], row_in_tile, tile_px[2]}];
        k = int'(tile_px[1:0]);
        return {ent[13:12], word[15 - 4 * k -: 4]};
    endfunction

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run stopped");
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (line_busy === 1'b1)
        else abort_run("line_busy did not rise after a start pulse");
    endtask

    task automatic read_back_line(input string name, input logic [8:0] sx,
                                  input logic [7:0] sy, input logic [7:0] vl);
        logic [5:0] exp;
        for (int i = 0; i < `TG_LINE_WIDTH; i++) begin
            rd_idx = 9'(i);
            @(negedge clk);
            exp = model_pixel(sx, sy, vl, i);
            assert (rd_data === exp)
            else abort_run($sformatf("ERR %s idx %0d expected %02h actual %02h",
                                     name, i, exp, rd_data));
        end
    endtask

    task automatic wait_line_done();
        while (line_busy !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        seed   = 32'h8f0c_dc01;
        reset  = 1'b1;
        start  = 1'b0;
        scrx   = 9'd0;
        scry   = 8'd0;
        vline  = 8'd0;
        rd_idx = 9'd0;
        vdata  = 16'd0;
        for (int a = 0; a < 8192; a++) begin
            vram[a] = 16'($random(seed));
        end

        repeat (10) @(negedge clk);
        reset = 1'b0;
        assert (line_busy === 1'b0)
        else abort_run("line_busy is high after reset");

        for (int n = 0; n < num_lines; n++) begin
            if (n == 0) begin
                cur_name = "zero_scroll";
                scrx = 9'd0;
                scry = 8'd0;
            end else begin
                cur_name = $sformatf("random_line_%0d", n);
                scrx = 9'($random(seed));
                scry = 8'($random(seed));
            end
            vline = 8'($random(seed));
            pulse_start();
            // Previous line is read while this one renders
            if (n > 0) begin
                read_back_line(prev_name, prev_scrx, prev_scry, prev_vline);
            end
            wait_line_done();
            // Whole render of the other bank has left the read bank intact
            if (n > 0) begin
                read_back_line(prev_name, prev_scrx, prev_scry, prev_vline);
            end
            prev_name  = cur_name;
            prev_scrx  = scrx;
            prev_scry  = scry;
            prev_vline = vline;
        end

        // One more swap makes the last line readable
        pulse_start();
        read_back_line(prev_name, prev_scrx, prev_scry, prev_vline);
        wait_line_done();

        $display("** PASS **");
        $finish;
    end

    //////////////////////////////
    // Timeout
    //////////////////////////////

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run("Timeout: the run did not finish within the cycle limit");
    end

endmodule

//--- tile_gfx.f
+incdir+include
rtl/tile_gfx_pkg.sv
rtl/tile_render_if.sv
rtl/tile_renderer.sv
rtl/line_buffer.sv
rtl/tile_fetcher.sv
rtl/tile_gfx.sv
tb/tile_gfx_checker.sv
tb/tile_gfx_tb.sv
